// ==== accel_pkg.sv ====
package accel_pkg;

	// word and address geometry of the unified buffer
	parameter int WORD_W = 16;
	parameter int BYTE_W = 8;
	parameter int BUFFER_DEPTH = 512;
	parameter int ADDR_W = $clog2(BUFFER_DEPTH);

	// words processed by one RUN
	parameter int RUN_LEN = 8;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [BYTE_W-1:0] byte_t;

	// opcode sits in the three lowest instruction bits
	parameter int OPCODE_W = 3;

	// codes 3, 6 and 7 are unused and decode as NOP
	typedef enum logic [OPCODE_W-1:0] {
		OP_STORE = 3'd0,
		OP_FETCH = 3'd1,
		OP_RUN   = 3'd2,
		OP_HALT  = 3'd4,
		OP_NOP   = 3'd5
	} opcode_e;

	// address field is instruction bits 15:7
	parameter int ADDR_LSB = 7;

	// flag bit positions
	parameter int FLAG_HIGH_BYTE = 3;
	parameter int FLAG_QUANT = 4;
	parameter int FLAG_RELU = 5;

	// quantizer: arithmetic shift, then clamp to a signed 4-bit range
	parameter int QUANT_SHIFT = 4;
	parameter int QUANT_MIN = -8;
	parameter int QUANT_MAX = 7;

endpackage

// ==== buffer_port_if.sv ====
`timescale 1ns/1ps

interface buffer_port_if;
	import accel_pkg::*;

	// request side, held steady until gnt
	logic  req;
	logic  we;
	addr_t addr;
	word_t wdata;

	// grant pulse, read data one cycle after it
	logic  gnt;
	word_t rdata;

	modport requester (
		output req,
		output we,
		output addr,
		output wdata,
		input  gnt,
		input  rdata
	);

	modport buffer (
		input  req,
		input  we,
		input  addr,
		input  wdata,
		output gnt,
		output rdata
	);

endinterface

// ==== uart_link.sv ====
`timescale 1ns/1ps

module uart_link #(
	parameter int CLKS_PER_BIT = 16
) (
	input  logic             clk,
	input  logic             rst_int,
	input  logic             rx,
	output logic             tx,
	output accel_pkg::byte_t rx_byte,
	output logic             rx_strobe,
	input  accel_pkg::byte_t tx_byte,
	input  logic             tx_start,
	output logic             tx_busy
);
	import accel_pkg::*;

	localparam int CNT_W = $clog2(CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);
	localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_e;

	rx_state_e        rx_state;
	logic             rx_meta;
	logic             rx_sync;
	logic [CNT_W-1:0] rx_cnt;
	logic [2:0]       rx_bit;
	byte_t            rx_shift;

	logic [CNT_W-1:0] tx_cnt;
	logic [3:0]       tx_bit;
	logic [BYTE_W:0]  tx_shift;

	// line idles high, so the synchronizer resets to 1
	always_ff @(posedge clk) begin
		if (rst_int) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_int) begin
			rx_state <= RX_IDLE;
			rx_cnt <= '0;
			rx_bit <= '0;
			rx_strobe <= 1'b0;
		end else begin
			rx_strobe <= 1'b0;
			rx_cnt <= rx_cnt + 1'b1;
			case (rx_state)
				RX_IDLE: begin
					rx_cnt <= '0;
					if (!rx_sync)
						rx_state <= RX_START;
				end
				RX_START: begin
					// recheck at mid start bit to drop glitches
					if (rx_cnt == HALF_LAST) begin
						rx_cnt <= '0;
						rx_bit <= '0;
						rx_state <= rx_sync ? RX_IDLE : RX_DATA;
					end
				end
				RX_DATA: begin
					if (rx_cnt == BIT_LAST) begin
						rx_cnt <= '0;
						rx_bit <= rx_bit + 1'b1;
						if (rx_bit == 3'd7)
							rx_state <= RX_STOP;
					end
				end
				default: begin
					// frame is kept only with a high stop bit
					if (rx_cnt == BIT_LAST) begin
						rx_strobe <= rx_sync;
						rx_state <= RX_IDLE;
					end
				end
			endcase
		end
	end

	// lsb arrives first
	always_ff @(posedge clk) begin
		if (rx_state == RX_DATA && rx_cnt == BIT_LAST)
			rx_shift <= {rx_sync, rx_shift[BYTE_W-1:1]};
	end

	assign rx_byte = rx_shift;

	// start bit goes out the cycle after tx_start, busy spans ten bit periods
	always_ff @(posedge clk) begin
		if (rst_int) begin
			tx_busy <= 1'b0;
			tx <= 1'b1;
			tx_cnt <= '0;
			tx_bit <= '0;
		end else if (!tx_busy) begin
			if (tx_start) begin
				tx_busy <= 1'b1;
				tx <= 1'b0;
				tx_cnt <= '0;
				tx_bit <= '0;
			end
		end else if (tx_cnt == BIT_LAST) begin
			tx_cnt <= '0;
			tx_bit <= tx_bit + 1'b1;
			tx <= tx_shift[0];
			if (tx_bit == 4'd9)
				tx_busy <= 1'b0;
		end else begin
			tx_cnt <= tx_cnt + 1'b1;
		end
	end

	// ones shift in behind the data and form the stop bit
	always_ff @(posedge clk) begin
		if (!tx_busy && tx_start)
			tx_shift <= {1'b1, tx_byte};
		else if (tx_busy && tx_cnt == BIT_LAST)
			tx_shift <= {1'b1, tx_shift[BYTE_W:1]};
	end

endmodule

// ==== unified_buffer.sv ====
`timescale 1ns/1ps

module unified_buffer (
	input logic           clk,
	buffer_port_if.buffer cmd_port,
	buffer_port_if.buffer eng_port
);
	import accel_pkg::*;

	word_t mem [BUFFER_DEPTH];
	word_t rd_q;

	logic  sel_any;
	logic  sel_we;
	addr_t sel_addr;
	word_t sel_wdata;

	// fixed priority, the command port always wins
	assign cmd_port.gnt = cmd_port.req;
	assign eng_port.gnt = eng_port.req & ~cmd_port.req;

	assign sel_any = cmd_port.req | eng_port.req;

	always_comb begin
		if (cmd_port.req) begin
			sel_we = cmd_port.we;
			sel_addr = cmd_port.addr;
			sel_wdata = cmd_port.wdata;
		end else begin
			sel_we = eng_port.we;
			sel_addr = eng_port.addr;
			sel_wdata = eng_port.wdata;
		end
	end

	// single port: one access per cycle, either a write or a read
	always_ff @(posedge clk) begin
		if (sel_any) begin
			if (sel_we)
				mem[sel_addr] <= sel_wdata;
			else
				rd_q <= mem[sel_addr];
		end
	end

	// read register is shared, each port looks at it the cycle after its own grant
	assign cmd_port.rdata = rd_q;
	assign eng_port.rdata = rd_q;

endmodule

// ==== command_unit.sv ====
`timescale 1ns/1ps

module command_unit (
	input  logic             clk,
	input  logic             rst_int,
	input  accel_pkg::byte_t rx_byte,
	input  logic             rx_strobe,
	output accel_pkg::byte_t tx_byte,
	output logic             tx_start,
	input  logic             tx_busy,
	buffer_port_if.requester mem,
	output logic             run_start,
	output accel_pkg::addr_t run_addr,
	output logic             run_quant,
	output logic             run_relu,
	input  logic             run_busy
);
	import accel_pkg::*;

	typedef enum logic [2:0] {
		S_INSTR,
		S_DECODE,
		S_ARGS,
		S_STORE,
		S_FETCH_REQ,
		S_FETCH_DATA,
		S_FETCH_TX,
		S_HALT
	} state_e;

	state_e     state;
	byte_t      byte_q;
	logic       byte_vld;
	logic       byte_take;
	logic       instr_half;
	word_t      instr;
	opcode_e    opcode;
	addr_t      instr_addr;
	logic [1:0] arg_cnt;
	word_t      store_val;
	addr_t      store_dst;

	assign opcode = opcode_e'(instr[OPCODE_W-1:0]);
	assign instr_addr = instr[WORD_W-1:ADDR_LSB];

	// one byte of slack, so a byte landing during a short stall survives
	assign byte_take = byte_vld && (state == S_INSTR || state == S_ARGS);

	always_ff @(posedge clk) begin
		if (rst_int) begin
			state <= S_INSTR;
			byte_vld <= 1'b0;
			instr_half <= 1'b0;
			arg_cnt <= '0;
		end else begin
			if (rx_strobe && state != S_HALT)
				byte_vld <= 1'b1;
			else if (byte_take)
				byte_vld <= 1'b0;

			case (state)
				S_INSTR: begin
					if (byte_vld) begin
						instr_half <= ~instr_half;
						if (instr_half)
							state <= S_DECODE;
					end
				end
				S_DECODE: begin
					case (opcode)
						OP_STORE: begin
							arg_cnt <= '0;
							state <= S_ARGS;
						end
						OP_FETCH: state <= S_FETCH_REQ;
						// run_start fires here once the engine is idle
						OP_RUN: begin
							if (!run_busy)
								state <= S_INSTR;
						end
						OP_HALT: state <= S_HALT;
						OP_NOP: state <= S_INSTR;
						default: state <= S_INSTR;
					endcase
				end
				S_ARGS: begin
					if (byte_vld) begin
						arg_cnt <= arg_cnt + 1'b1;
						if (arg_cnt == 2'd3)
							state <= S_STORE;
					end
				end
				S_STORE: begin
					if (mem.gnt)
						state <= S_INSTR;
				end
				S_FETCH_REQ: begin
					if (mem.gnt)
						state <= S_FETCH_DATA;
				end
				S_FETCH_DATA: state <= S_FETCH_TX;
				S_FETCH_TX: begin
					if (!tx_busy)
						state <= S_INSTR;
				end
				default: state <= S_HALT;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rx_strobe)
			byte_q <= rx_byte;
		// instruction arrives low byte first
		if (state == S_INSTR && byte_vld) begin
			if (instr_half)
				instr[WORD_W-1:BYTE_W] <= byte_q;
			else
				instr[BYTE_W-1:0] <= byte_q;
		end
		// store arguments: value lo, value hi, address lo, address hi
		if (state == S_ARGS && byte_vld) begin
			case (arg_cnt)
				2'd0: store_val[BYTE_W-1:0] <= byte_q;
				2'd1: store_val[WORD_W-1:BYTE_W] <= byte_q;
				2'd2: store_dst[BYTE_W-1:0] <= byte_q;
				default: store_dst[ADDR_W-1:BYTE_W] <= byte_q[ADDR_W-BYTE_W-1:0];
			endcase
		end
		if (state == S_FETCH_DATA)
			tx_byte <= instr[FLAG_HIGH_BYTE] ? mem.rdata[WORD_W-1:BYTE_W] : mem.rdata[BYTE_W-1:0];
	end

	assign tx_start = (state == S_FETCH_TX) && !tx_busy;

	assign run_start = (state == S_DECODE) && (opcode == OP_RUN) && !run_busy;
	assign run_addr = instr_addr;
	assign run_quant = instr[FLAG_QUANT];
	assign run_relu = instr[FLAG_RELU];

	assign mem.req = (state == S_STORE) || (state == S_FETCH_REQ);
	assign mem.we = (state == S_STORE);
	assign mem.addr = (state == S_STORE) ? store_dst : instr_addr;
	assign mem.wdata = store_val;

endmodule

// ==== postproc_engine.sv ====
`timescale 1ns/1ps

module postproc_engine #(
	parameter int ALPHA_SHIFT = 1
) (
	input  logic             clk,
	input  logic             rst_int,
	input  logic             run_start,
	input  accel_pkg::addr_t run_addr,
	input  logic             run_quant,
	input  logic             run_relu,
	output logic             run_busy,
	buffer_port_if.requester mem
);
	import accel_pkg::*;

	localparam int IDX_W = $clog2(RUN_LEN);

	typedef enum logic [1:0] {
		E_IDLE,
		E_READ,
		E_WRITE
	} eng_state_e;

	eng_state_e               state;
	logic [IDX_W-1:0]         idx;
	logic                     fresh;
	addr_t                    base;
	logic                     quant_q;
	logic                     relu_q;
	word_t                    hold_q;
	logic signed [WORD_W-1:0] shifted;
	logic signed [WORD_W-1:0] q_val;
	logic signed [WORD_W-1:0] result;

	// quantize, then leaky relu, both optional
	always_comb begin
		shifted = $signed(mem.rdata) >>> QUANT_SHIFT;
		q_val = mem.rdata;
		if (quant_q) begin
			if (shifted > QUANT_MAX)
				q_val = WORD_W'(QUANT_MAX);
			else if (shifted < QUANT_MIN)
				q_val = WORD_W'(QUANT_MIN);
			else
				q_val = shifted;
		end
		result = q_val;
		if (relu_q && q_val < 0)
			result = q_val >>> ALPHA_SHIFT;
	end

	always_ff @(posedge clk) begin
		if (rst_int) begin
			state <= E_IDLE;
			idx <= '0;
			fresh <= 1'b0;
		end else begin
			case (state)
				E_IDLE: begin
					if (run_start) begin
						idx <= '0;
						state <= E_READ;
					end
				end
				E_READ: begin
					if (mem.gnt) begin
						fresh <= 1'b1;
						state <= E_WRITE;
					end
				end
				E_WRITE: begin
					fresh <= 1'b0;
					if (mem.gnt) begin
						idx <= idx + 1'b1;
						state <= (idx == IDX_W'(RUN_LEN - 1)) ? E_IDLE : E_READ;
					end
				end
				default: state <= E_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == E_IDLE && run_start) begin
			base <= run_addr;
			quant_q <= run_quant;
			relu_q <= run_relu;
		end
		// rdata is ours for one cycle only, keep the result while the write stalls
		if (fresh)
			hold_q <= result;
	end

	assign run_busy = (state != E_IDLE);

	// req stays up across read and write, so it never drops before a grant
	assign mem.req = (state == E_READ) || (state == E_WRITE);
	assign mem.we = (state == E_WRITE);
	assign mem.addr = base + addr_t'(idx);
	assign mem.wdata = fresh ? word_t'(result) : hold_q;

endmodule

// ==== accel_top.sv ====
`timescale 1ns/1ps

module accel_top #(
	parameter int CLKS_PER_BIT = 16,
	parameter int ALPHA_SHIFT = 1
) (
	input  logic clk,
	input  logic rst_int,
	input  logic rx,
	output logic tx
);
	import accel_pkg::*;

	byte_t rx_byte;
	logic  rx_strobe;
	byte_t tx_byte;
	logic  tx_start;
	logic  tx_busy;

	logic  run_start;
	addr_t run_addr;
	logic  run_quant;
	logic  run_relu;
	logic  run_busy;

	// command unit and engine each own one buffer port
	buffer_port_if cmd_bus ();
	buffer_port_if eng_bus ();

	uart_link #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) i_uart (
		.clk      (clk),
		.rst_int  (rst_int),
		.rx       (rx),
		.tx       (tx),
		.rx_byte  (rx_byte),
		.rx_strobe(rx_strobe),
		.tx_byte  (tx_byte),
		.tx_start (tx_start),
		.tx_busy  (tx_busy)
	);

	unified_buffer i_buffer (
		.clk     (clk),
		.cmd_port(cmd_bus.buffer),
		.eng_port(eng_bus.buffer)
	);

	command_unit i_cmd (
		.clk      (clk),
		.rst_int  (rst_int),
		.rx_byte  (rx_byte),
		.rx_strobe(rx_strobe),
		.tx_byte  (tx_byte),
		.tx_start (tx_start),
		.tx_busy  (tx_busy),
		.mem      (cmd_bus.requester),
		.run_start(run_start),
		.run_addr (run_addr),
		.run_quant(run_quant),
		.run_relu (run_relu),
		.run_busy (run_busy)
	);

	postproc_engine #(
		.ALPHA_SHIFT(ALPHA_SHIFT)
	) i_engine (
		.clk      (clk),
		.rst_int  (rst_int),
		.run_start(run_start),
		.run_addr (run_addr),
		.run_quant(run_quant),
		.run_relu (run_relu),
		.run_busy (run_busy),
		.mem      (eng_bus.requester)
	);

endmodule

// ==== accel_assert.sv ====
`timescale 1ns/1ps

module accel_assert (
	input logic clk,
	input logic rst_int,
	input logic tx,
	input logic cmd_req,
	input logic cmd_gnt,
	input logic eng_req,
	input logic eng_gnt
);

	int unsigned fail_count = 0;

	// tx is registered, it reaches idle one edge into reset
	tx_idle_in_reset: assert property (@(posedge clk) rst_int && $past(rst_int) |-> tx)
		else begin
			$error("tx low while reset is held");
			fail_count++;
		end

	grants_exclusive: assert property (@(posedge clk) disable iff (rst_int)
		!(cmd_gnt && eng_gnt))
		else begin
			$error("both buffer ports granted in one cycle");
			fail_count++;
		end

	cmd_gnt_has_req: assert property (@(posedge clk) disable iff (rst_int) cmd_gnt |-> cmd_req)
		else begin
			$error("command port granted without a request");
			fail_count++;
		end

	eng_gnt_has_req: assert property (@(posedge clk) disable iff (rst_int) eng_gnt |-> eng_req)
		else begin
			$error("engine port granted without a request");
			fail_count++;
		end

	// a stalled engine request must wait for its grant
	eng_req_held: assert property (@(posedge clk) disable iff (rst_int)
		eng_req && !eng_gnt |=> eng_req)
		else begin
			$error("engine request dropped before its grant");
			fail_count++;
		end

endmodule

bind accel_top accel_assert i_assert (
	.clk    (clk),
	.rst_int(rst_int),
	.tx     (tx),
	.cmd_req(cmd_bus.req),
	.cmd_gnt(cmd_bus.gnt),
	.eng_req(eng_bus.req),
	.eng_gnt(eng_bus.gnt)
);

// ==== tb_accel_top.sv ====
`timescale 1ns/1ps

module tb_accel_top;
	import accel_pkg::*;

	localparam int CLKS_PER_BIT = 16;
	localparam int ALPHA_SHIFT = 1;
	localparam int FRAME_CYCLES = 10 * CLKS_PER_BIT;
	localparam int RUN_WAIT = 4 * RUN_LEN;
	// frames per command on both serial lines together
	localparam int STORE_FRAMES = 6;
	localparam int FETCH_FRAMES = 3;
	localparam int RUN_FRAMES = 2;
	localparam int TOTAL_FRAMES = 28 * STORE_FRAMES + 57 * FETCH_FRAMES + 3 * RUN_FRAMES + 7;
	localparam int TIMEOUT_CYCLES = TOTAL_FRAMES * FRAME_CYCLES * 2;

	logic        clk;
	logic        rst_int;
	logic        rx;
	logic        tx;
	int          cycles = 0;
	int          errors = 0;
	int          tests_passed = 0;
	int          tests_failed = 0;
	logic [15:0] lfsr = 16'd24228;
	word_t       model [BUFFER_DEPTH];

	accel_top #(
		.CLKS_PER_BIT(CLKS_PER_BIT),
		.ALPHA_SHIFT (ALPHA_SHIFT)
	) i_dut (
		.clk    (clk),
		.rst_int(rst_int),
		.rx     (rx),
		.tx     (tx)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > TIMEOUT_CYCLES) begin
			$display("timeout: no progress within %0d cycles", TIMEOUT_CYCLES);
			$display("Result: FAILED");
			$finish;
		end
	end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic word_t make_instr(opcode_e op, addr_t addr, word_t flags);
		return {addr, 4'b0000, op} | flags;
	endfunction

	// expected engine result, straight from the quantize and leaky relu rules
	function automatic word_t post_expect(word_t w, logic quant, logic relu);
		int v;
		v = $signed(w);
		if (quant) begin
			v = v >>> QUANT_SHIFT;
			if (v > QUANT_MAX)
				v = QUANT_MAX;
			else if (v < QUANT_MIN)
				v = QUANT_MIN;
		end
		if (relu && v < 0)
			v = v >>> ALPHA_SHIFT;
		return word_t'(v);
	endfunction

	task automatic draw_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[14:0], lfsr[0]};
		end
	endtask

	// kind 1 large positive, 2 large negative, 3 small signed, else anything
	task automatic draw_word(input int kind, output word_t w);
		draw_bits(16, w);
		case (kind)
			1: w[15:14] = 2'b01;
			2: w[15:14] = 2'b10;
			3: w[15:8] = {8{w[7]}};
			default: ;
		endcase
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#2;
		rst_int = 1'b1;
		repeat (10) @(posedge clk);
		#2;
		rst_int = 1'b0;
	endtask

	task automatic send_byte(input byte_t b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			#2;
			rx = frame[i];
			repeat (CLKS_PER_BIT - 1) @(posedge clk);
		end
	endtask

	task automatic send_word(input word_t w);
		send_byte(w[7:0]);
		send_byte(w[15:8]);
	endtask

	task automatic recv_byte(output byte_t b);
		b = '0;
		while (tx !== 1'b0)
			@(negedge clk);
		// step to mid start bit, then one bit period per data bit
		repeat (CLKS_PER_BIT / 2) @(negedge clk);
		for (int i = 0; i < 8; i++) begin
			repeat (CLKS_PER_BIT) @(negedge clk);
			b[i] = tx;
		end
		repeat (CLKS_PER_BIT) @(negedge clk);
		assert (tx === 1'b1) else begin
			$display("stop bit of the reply frame is low");
			errors++;
		end
	endtask

	task automatic store_word(input addr_t addr, input word_t val);
		send_word(make_instr(OP_STORE, '0, '0));
		send_word(val);
		send_word(word_t'(addr));
		model[addr] = val;
	endtask

	task automatic fetch_check(input addr_t addr, input logic high);
		word_t flags;
		byte_t got;
		byte_t exp;
		flags = '0;
		flags[FLAG_HIGH_BYTE] = high;
		exp = high ? model[addr][15:8] : model[addr][7:0];
		fork
			send_word(make_instr(OP_FETCH, addr, flags));
			recv_byte(got);
		join
		assert (got === exp) else begin
			$display("mismatch tx_byte addr %h high %0d: expected %h got %h",
				addr, high, exp, got);
			errors++;
		end
	endtask

	task automatic fill_block(input addr_t base, input int mode);
		word_t w;
		for (int i = 0; i < RUN_LEN; i++) begin
			draw_word((mode == 1) ? 1 + i % 2 : (mode == 2) ? i % 4 : 0, w);
			store_word(base + addr_t'(i), w);
		end
	endtask

	task automatic run_job(input addr_t base, input logic quant, input logic relu);
		word_t flags;
		addr_t a;
		flags = '0;
		flags[FLAG_QUANT] = quant;
		flags[FLAG_RELU] = relu;
		send_word(make_instr(OP_RUN, base, flags));
		for (int i = 0; i < RUN_LEN; i++) begin
			a = base + addr_t'(i);
			model[a] = post_expect(model[a], quant, relu);
		end
	endtask

	task automatic check_block(input addr_t base);
		for (int i = 0; i < RUN_LEN; i++) begin
			fetch_check(base + addr_t'(i), 1'b0);
			fetch_check(base + addr_t'(i), 1'b1);
		end
	endtask

	task automatic watch_quiet(input int n, output int lows);
		lows = 0;
		repeat (n) begin
			@(negedge clk);
			if (tx !== 1'b1)
				lows++;
		end
	endtask

	task automatic finish_test(input int num, input string name, input int err_start);
		if (errors == err_start) begin
			tests_passed++;
			$display("test %0d %s: pass", num, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: fail with %0d errors", num, name, errors - err_start);
		end
	endtask

	initial begin
		logic [15:0] r;
		addr_t       keep_addr;
		addr_t       a0;
		addr_t       a1;
		addr_t       base;
		word_t       v0;
		word_t       v1;
		int          e0;
		int          lows;
		rx = 1'b1;
		rst_int = 1'b1;
		apply_reset();

		e0 = errors;
		draw_bits(9, r);
		keep_addr = addr_t'(r);
		draw_word(0, v0);
		store_word(keep_addr, v0);
		fetch_check(keep_addr, 1'b0);
		fetch_check(keep_addr, 1'b1);
		finish_test(1, "store_fetch", e0);

		e0 = errors;
		draw_bits(9, r);
		a0 = addr_t'(r);
		draw_bits(9, r);
		a1 = addr_t'(r);
		if (a1 == a0)
			a1 = a0 + 1'b1;
		draw_word(0, v0);
		draw_word(0, v1);
		store_word(a0, v0);
		store_word(a1, v1);
		fetch_check(a0, 1'b0);
		fetch_check(a0, 1'b1);
		fetch_check(a1, 1'b0);
		fetch_check(a1, 1'b1);
		finish_test(2, "two_addresses", e0);

		e0 = errors;
		draw_bits(9, r);
		base = addr_t'(r);
		fill_block(base, 1);
		run_job(base, 1'b0, 1'b1);
		repeat (RUN_WAIT) @(posedge clk);
		check_block(base);
		finish_test(3, "run_relu", e0);

		e0 = errors;
		draw_bits(9, r);
		base = addr_t'(r);
		fill_block(base, 2);
		run_job(base, 1'b1, 1'b1);
		repeat (RUN_WAIT) @(posedge clk);
		check_block(base);
		finish_test(4, "run_quant_relu", e0);

		// store sent right behind a run, outside its eight words
		e0 = errors;
		draw_bits(9, r);
		base = addr_t'(r);
		draw_bits(9, r);
		a1 = addr_t'(r);
		if (addr_t'(a1 - base) < RUN_LEN)
			a1 = a1 + addr_t'(RUN_LEN);
		draw_word(0, v1);
		fill_block(base, 0);
		run_job(base, 1'b1, 1'b0);
		store_word(a1, v1);
		fetch_check(a1, 1'b0);
		fetch_check(a1, 1'b1);
		check_block(base);
		finish_test(5, "run_with_store", e0);

		e0 = errors;
		send_word(make_instr(OP_HALT, '0, '0));
		send_word(make_instr(OP_FETCH, keep_addr, '0));
		watch_quiet(3 * FRAME_CYCLES, lows);
		assert (lows == 0) else begin
			$display("fetch was answered after halt, tx low for %0d cycles", lows);
			errors++;
		end
		apply_reset();
		fetch_check(keep_addr, 1'b0);
		finish_test(6, "halt_reset", e0);

		$display("tests passed %0d, failed %0d, assertion failures %0d",
			tests_passed, tests_failed, i_dut.i_assert.fail_count);
		if (tests_failed == 0 && i_dut.i_assert.fail_count == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// ==== accel_top.f ====
accel_pkg.sv
buffer_port_if.sv
uart_link.sv
unified_buffer.sv
command_unit.sv
postproc_engine.sv
accel_top.sv
accel_assert.sv
tb_accel_top.sv

// ==== Bender.yml ====
package:
  name: accel_top

sources:
  - accel_pkg.sv
  - buffer_port_if.sv
  - uart_link.sv
  - unified_buffer.sv
  - command_unit.sv
  - postproc_engine.sv
  - accel_top.sv
  - target: test
    files:
      - accel_assert.sv
      - tb_accel_top.sv
